/* verilog/bpu_pkg.sv */
// *************************************************
// Branch prediction unit shared types
// Machine word, 2-bit counter states, the fetch
// lookup answer and the memory-stage resolve record
// *************************************************
`default_nettype none

package bpu_pkg;

    // 32-bit machine word for program counters and targets
    typedef logic [31:0] word_t;

    // Saturating counter states, ordered from not taken to taken
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } branch_pred_t;

    // Answer returned to the fetch stage
    typedef struct packed {
        logic  predict;
        word_t target;
    } fetch_pred_t;

    // Resolved branch from the memory stage
    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  taken;
        // What fetch acted on for this branch
        logic  predicted;
        word_t target_pred;
        word_t target_res;
    } resolve_t;

    // Saturating statistics count
    typedef logic [15:0] count_t;

    // Resolved branches and mispredicts
    typedef struct packed {
        count_t resolved;
        count_t missed;
    } stats_t;

endpackage

`default_nettype wire

/* verilog/pattern_history_table.sv */
// *************************************************
// Pattern history table
// 2-bit saturating counters per index, read in the
// same cycle, stepped on a resolve strobe
// *************************************************
`timescale 1ns/10ps
`default_nettype none

module pattern_history_table #(
    parameter int BTB_BITS = 8
) (
    input  wire                 clk,
    input  wire                 nrst,
    input  wire  [BTB_BITS-1:0] rd_index,
    input  wire                 wr_en,
    input  wire  [BTB_BITS-1:0] wr_index,
    input  wire                 taken,
    output logic                predict
);

    localparam int ENTRIES = 1 << BTB_BITS;

    bpu_pkg::branch_pred_t counters [0:ENTRIES-1];
    bpu_pkg::branch_pred_t cur_state;
    bpu_pkg::branch_pred_t next_state;
    bpu_pkg::branch_pred_t rd_state;

    // Step the written entry one state, holding at both ends
    always_comb begin
        cur_state  = counters[wr_index];
        next_state = cur_state;
        case (cur_state)
            bpu_pkg::STRONG_NOT_TAKEN: begin
                if (taken) begin
                    next_state = bpu_pkg::WEAK_NOT_TAKEN;
                end
            end
            bpu_pkg::WEAK_NOT_TAKEN: begin
                if (taken) begin
                    next_state = bpu_pkg::WEAK_TAKEN;
                end else begin
                    next_state = bpu_pkg::STRONG_NOT_TAKEN;
                end
            end
            bpu_pkg::WEAK_TAKEN: begin
                if (taken) begin
                    next_state = bpu_pkg::STRONG_TAKEN;
                end else begin
                    next_state = bpu_pkg::WEAK_NOT_TAKEN;
                end
            end
            bpu_pkg::STRONG_TAKEN: begin
                if (!taken) begin
                    next_state = bpu_pkg::WEAK_TAKEN;
                end
            end
            default: begin
                next_state = bpu_pkg::STRONG_NOT_TAKEN;
            end
        endcase
    end

    // Every entry starts as strong not taken
    always_ff @(posedge clk) begin
        if (!nrst) begin
            counters <= '{default: bpu_pkg::STRONG_NOT_TAKEN};
        end else if (wr_en) begin
            counters[wr_index] <= next_state;
        end
    end

    // Lookup sees the pre-edge entry, so a same-cycle update is not visible
    assign rd_state = counters[rd_index];
    assign predict  = (rd_state == bpu_pkg::WEAK_TAKEN) ||
                      (rd_state == bpu_pkg::STRONG_TAKEN);

    // Update index comes from the memory stage pc and must be clean
    a_wr_index_known: assert property (
        @(posedge clk) disable iff (!nrst)
        wr_en |-> !$isunknown(wr_index)
    );

endmodule

`default_nettype wire

/* verilog/branch_target_buffer.sv */
// *************************************************
// Branch target buffer
// One resolved target word per index, no tags
// Combinational read, written on a resolve strobe
// *************************************************
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_BITS = 8
) (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire           [BTB_BITS-1:0] rd_index,
    output bpu_pkg::word_t               target,
    input  wire                          wr_en,
    input  wire           [BTB_BITS-1:0] wr_index,
    input  wire bpu_pkg::word_t          wr_target
);

    localparam int ENTRIES = 1 << BTB_BITS;

    bpu_pkg::word_t targets [0:ENTRIES-1];

    // Aliasing branches simply overwrite each other
    always_ff @(posedge clk) begin
        if (!nrst) begin
            targets <= '{default: '0};
        end else if (wr_en) begin
            targets[wr_index] <= wr_target;
        end
    end

    assign target = targets[rd_index];

    // A resolved target must never carry X into the table
    a_wr_target_known: assert property (
        @(posedge clk) disable iff (!nrst)
        wr_en |-> !$isunknown(wr_target)
    );

endmodule

`default_nettype wire

/* verilog/mispredict_check.sv */
// *************************************************
// Mispredict check
// Compares the prediction fetch used against the
// resolved outcome, raises flush, and counts
// resolved branches and mispredicts
// *************************************************
`timescale 1ns/10ps
`default_nettype none

module mispredict_check (
    input  wire                       clk,
    input  wire                       nrst,
    input  wire bpu_pkg::resolve_t    resolve,
    output logic                      flush,
    output bpu_pkg::count_t           resolved_count,
    output bpu_pkg::count_t           missed_count
);

    logic miss;

    // Predicted taken: wrong if not taken or sent to the wrong place
    // Predicted not taken: wrong only if taken
    always_comb begin
        if (resolve.predicted) begin
            miss = !resolve.taken || (resolve.target_res != resolve.target_pred);
        end else begin
            miss = resolve.taken;
        end
    end

    assign flush = resolve.valid && miss;

    // Saturating statistics
    always_ff @(posedge clk) begin
        if (!nrst) begin
            resolved_count <= '0;
            missed_count   <= '0;
        end else if (resolve.valid) begin
            if (resolved_count != '1) begin
                resolved_count <= resolved_count + 16'd1;
            end
            if (flush && missed_count != '1) begin
                missed_count <= missed_count + 16'd1;
            end
        end
    end

    // Each mispredict is also a resolved branch
    a_missed_le_resolved: assert property (
        @(posedge clk) disable iff (!nrst)
        missed_count <= resolved_count
    );

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
// *************************************************
// Branch prediction unit top level
// Slices table indices from the fetch and resolve
// program counters, joins the counter table, the
// target buffer and the mispredict check
// *************************************************
`timescale 1ns/10ps
`default_nettype none

module branch_unit #(
    parameter int BTB_BITS = 8
) (
    input  wire                         clk,
    input  wire                         nrst,
    input  wire bpu_pkg::word_t         fetch_pc,
    output bpu_pkg::fetch_pred_t        fetch_pred,
    input  wire bpu_pkg::resolve_t      resolve,
    output logic                        flush,
    output bpu_pkg::stats_t             stats
);

    logic [BTB_BITS-1:0] fetch_index;
    logic [BTB_BITS-1:0] update_index;
    logic                fetch_predict;
    bpu_pkg::word_t      fetch_target;
    bpu_pkg::count_t     resolved_count;
    bpu_pkg::count_t     missed_count;

    // Word address bits, byte offset dropped
    assign fetch_index  = fetch_pc[BTB_BITS+1:2];
    assign update_index = resolve.pc[BTB_BITS+1:2];

    pattern_history_table #(
        .BTB_BITS (BTB_BITS)
    ) u_pht (
        .clk      (clk),
        .nrst     (nrst),
        .rd_index (fetch_index),
        .wr_en    (resolve.valid),
        .wr_index (update_index),
        .taken    (resolve.taken),
        .predict  (fetch_predict)
    );

    branch_target_buffer #(
        .BTB_BITS (BTB_BITS)
    ) u_btb (
        .clk       (clk),
        .nrst      (nrst),
        .rd_index  (fetch_index),
        .target    (fetch_target),
        .wr_en     (resolve.valid),
        .wr_index  (update_index),
        .wr_target (resolve.target_res)
    );

    mispredict_check u_check (
        .clk            (clk),
        .nrst           (nrst),
        .resolve        (resolve),
        .flush          (flush),
        .resolved_count (resolved_count),
        .missed_count   (missed_count)
    );

    assign fetch_pred = '{predict: fetch_predict, target: fetch_target};
    assign stats      = '{resolved: resolved_count, missed: missed_count};

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// **************************************************
// Testbench clock and reset
// 4 ns clock, synchronous reset held low at start
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release 1 ns after the edge, in step with the stimulus
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 nrst = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/branch_unit_checker.sv */
// **************************************************
// Branch unit checker
// Reference model of counters, targets and stats,
// compared with the DUT in the middle of each cycle
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module branch_unit_checker #(
    parameter int BTB_BITS = 8
) (
    input  wire                       clk,
    input  wire                       nrst,
    input  wire bpu_pkg::word_t       fetch_pc,
    input  wire bpu_pkg::fetch_pred_t fetch_pred,
    input  wire bpu_pkg::resolve_t    resolve,
    input  wire                       flush,
    input  wire bpu_pkg::stats_t      stats,
    output int                        check_count,
    output int                        error_count
);

    localparam int ENTRIES = 1 << BTB_BITS;

    // Counter encoding 0 strong not taken up to 3 strong taken
    logic [1:0]      model_ctr [0:ENTRIES-1];
    bpu_pkg::word_t  model_tgt [0:ENTRIES-1];
    bpu_pkg::count_t model_resolved;
    bpu_pkg::count_t model_missed;
    int              checks = 0;
    int              errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // Mispredict when the direction is wrong or a taken branch went elsewhere
    function automatic logic expected_flush(input bpu_pkg::resolve_t r);
        logic wrong_dir;
        logic wrong_tgt;
        wrong_dir = (r.predicted != r.taken);
        wrong_tgt = r.predicted && r.taken && (r.target_pred != r.target_res);
        return r.valid && (wrong_dir || wrong_tgt);
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // Model update on the same edge as the DUT
    always @(posedge clk) begin
        logic [BTB_BITS-1:0] idx;
        logic                miss;
        idx  = resolve.pc[BTB_BITS+1:2];
        miss = expected_flush(resolve);
        if (!nrst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                model_ctr[i] = 2'd0;
                model_tgt[i] = '0;
            end
            model_resolved = '0;
            model_missed   = '0;
        end else if (resolve.valid) begin
            if (resolve.taken && model_ctr[idx] != 2'd3) begin
                model_ctr[idx] = model_ctr[idx] + 2'd1;
            end else if (!resolve.taken && model_ctr[idx] != 2'd0) begin
                model_ctr[idx] = model_ctr[idx] - 2'd1;
            end
            model_tgt[idx] = resolve.target_res;
            if (model_resolved != '1) begin
                model_resolved = model_resolved + 16'd1;
            end
            if (miss && model_missed != '1) begin
                model_missed = model_missed + 16'd1;
            end
        end
    end

    // Inputs settle 1 ns after the rising edge, so the falling edge is safe
    always @(negedge clk) begin
        logic [BTB_BITS-1:0] idx;
        idx = fetch_pc[BTB_BITS+1:2];
        if (nrst) begin
            compare("fetch_pred.predict", 32'(model_ctr[idx] >= 2'd2),
                    32'(fetch_pred.predict));
            compare("fetch_pred.target", model_tgt[idx], fetch_pred.target);
            compare("flush", 32'(expected_flush(resolve)), 32'(flush));
            compare("stats.resolved", 32'(model_resolved), 32'(stats.resolved));
            compare("stats.missed", 32'(model_missed), 32'(stats.missed));
        end
    end

endmodule

`default_nettype wire

/* tb/branch_unit_tb.sv */
// **************************************************
// Branch prediction unit testbench
// Directed and random resolve traffic against the
// DUT, checked by the reference model
// **************************************************
`timescale 1ns/10ps
`default_nettype none

module branch_unit_tb;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_CYCLES  = 1000;

    logic                 clk;
    logic                 nrst;
    bpu_pkg::word_t       fetch_pc;
    bpu_pkg::fetch_pred_t fetch_pred;
    bpu_pkg::resolve_t    resolve;
    logic                 flush;
    bpu_pkg::stats_t      stats;
    int                   check_count;
    int                   error_count;
    int                   errors_seen = 0;
    int                   cycles = 0;
    bpu_pkg::word_t       pc_pool [0:7];
    bpu_pkg::word_t       tgt_pool [0:3];

    tb_clock_gen #(.RESET_CYCLES(8)) u_clock_gen (.clk(clk), .nrst(nrst));

    branch_unit u_branch_unit (.*);

    branch_unit_checker u_checker (.*);

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One strobe, then an idle cycle so the lookup sees the new entry
    task automatic send_resolve(input bpu_pkg::word_t pc, input logic is_taken,
                                input logic was_pred, input bpu_pkg::word_t tgt_pred,
                                input bpu_pkg::word_t tgt_res);
        resolve = '{valid: 1'b1, pc: pc, taken: is_taken, predicted: was_pred,
                    target_pred: tgt_pred, target_res: tgt_res};
        next_cycle();
        resolve.valid = 1'b0;
        next_cycle();
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, error_count - errors_seen);
        errors_seen = error_count;
    endtask

    // Pool entries 4..7 alias entries 0..3 on the index bits
    task automatic fill_pools();
        bpu_pkg::word_t r;
        for (int i = 0; i < 4; i++) begin
            r = $urandom();
            pc_pool[i]     = {r[31:2], 2'b00};
            pc_pool[i + 4] = pc_pool[i] ^ 32'h0010_0000;
            r = $urandom();
            tgt_pool[i]    = {r[31:2], 2'b00};
        end
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 20; i++) begin
            fetch_pc = $urandom();
            next_cycle();
        end
        report_test("reset state");
    endtask

    task automatic test_counter_walk();
        fetch_pc = 32'h0000_1040;
        repeat (4) send_resolve(fetch_pc, 1'b1, 1'b0, '0, 32'h0000_2000);
        repeat (4) send_resolve(fetch_pc, 1'b0, 1'b1, 32'h0000_2000, 32'h0000_2000);
        report_test("counter walk");
    endtask

    task automatic test_target_capture();
        fetch_pc = 32'h0000_220c;
        send_resolve(32'h0000_2208, 1'b1, 1'b0, '0, 32'h0000_9ab0);
        fetch_pc = 32'h0040_2208;
        next_cycle();
        fetch_pc = 32'h0000_2208;
        send_resolve(32'h0040_2208, 1'b1, 1'b1, 32'h0000_9ab0, 32'h0000_7f00);
        fetch_pc = 32'h0000_220c;
        next_cycle();
        report_test("target capture");
    endtask

    task automatic test_flush_rule();
        fetch_pc = 32'h0000_3000;
        send_resolve(32'h0000_3100, 1'b0, 1'b0, '0, 32'h0000_4000);
        send_resolve(32'h0000_3100, 1'b1, 1'b0, '0, 32'h0000_4000);
        send_resolve(32'h0000_3100, 1'b0, 1'b1, 32'h0000_4000, 32'h0000_4000);
        send_resolve(32'h0000_3100, 1'b1, 1'b1, 32'h0000_4000, 32'h0000_4000);
        send_resolve(32'h0000_3100, 1'b1, 1'b1, 32'h0000_4400, 32'h0000_4000);
        report_test("flush rule");
    endtask

    task automatic test_random_mix();
        bpu_pkg::word_t r;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r = $urandom();
            fetch_pc              = pc_pool[r[2:0]];
            resolve.valid         = r[3];
            resolve.pc            = pc_pool[r[6:4]];
            resolve.taken         = r[7];
            resolve.predicted     = r[8];
            resolve.target_res    = tgt_pool[r[10:9]];
            resolve.target_pred   = r[11] ? resolve.target_res : tgt_pool[r[13:12]];
            next_cycle();
        end
        resolve.valid = 1'b0;
        next_cycle();
        report_test("random mix");
    endtask

    initial begin
        void'($urandom(32'hb17da375));
        fetch_pc = '0;
        resolve  = '0;
        fill_pools();
        @(posedge nrst);
        next_cycle();
        test_reset_state();
        test_counter_walk();
        test_target_capture();
        test_flush_rule();
        test_random_mix();
        $display("Done: %0d checks passed, %0d errors",
                 check_count - error_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Guard against a stuck run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
verilog/bpu_pkg.sv
verilog/pattern_history_table.sv
verilog/branch_target_buffer.sv
verilog/mispredict_check.sv
verilog/branch_unit.sv
tb/tb_clock_gen.sv
tb/branch_unit_checker.sv
tb/branch_unit_tb.sv

/* Makefile */
SIM = obj_dir/Vbranch_unit_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): project.f $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f project.f --top-module branch_unit_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf obj_dir
